// ==== ex_checker.sv ====
`timescale 1ns/100ps

module ex_checker (
    input  logic clk,
    input  logic check_en,
    input  int test_id,
    input  logic exp_valid,
    input  exec_pkg::xword_t exp_result,
    input  logic exp_write,
    input  logic exp_taken,
    input  exec_pkg::xword_t exp_target,
    input  exec_pkg::regno_t exp_rd,
    input  logic result_valid,
    input  exec_pkg::xword_t result,
    input  logic write_rd,
    input  logic branch_taken,
    input  exec_pkg::xword_t branch_target,
    input  exec_pkg::regno_t rd_regno_out,
    output int pass_count,
    output int fail_count,
    output int done_count
);

    int passes = 0;
    int fails = 0;
    logic pend = 1'b0;
    int pend_id;
    logic e_valid;
    logic e_write;
    logic e_taken;
    exec_pkg::xword_t e_result;
    exec_pkg::xword_t e_target;
    exec_pkg::regno_t e_rd;

    assign pass_count = passes;
    assign fail_count = fails;
    assign done_count = passes + fails;

    task automatic check_word(input string name, input exec_pkg::xword_t exp,
                              input exec_pkg::xword_t got, inout bit bad);
        if (got !== exp)
        begin
            $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
            bad = 1;
        end
    endtask

    // Expected values line up with the DUT outputs one edge after issue
    always @(posedge clk)
    begin
        pend <= check_en;
        pend_id <= test_id;
        e_valid <= exp_valid;
        e_write <= exp_write;
        e_taken <= exp_taken;
        e_result <= exp_result;
        e_target <= exp_target;
        e_rd <= exp_rd;
    end

    always @(negedge clk)
    begin
        bit bad;
        bad = 0;
        if (pend)
        begin
            if (e_valid && result_valid !== 1'b1)
            begin
                $display("test %0d: result_valid did not appear one cycle after issue",
                         pend_id);
                bad = 1;
            end
            else
            begin
                check_word("result_valid", 64'(e_valid), 64'(result_valid), bad);
                check_word("write_rd", 64'(e_write), 64'(write_rd), bad);
                check_word("branch_taken", 64'(e_taken), 64'(branch_taken), bad);
                if (e_valid && e_write)
                begin
                    check_word("result", e_result, result, bad);
                    check_word("rd_regno_out", 64'(e_rd), 64'(rd_regno_out), bad);
                end
                if (e_valid)
                    check_word("branch_target", e_target, branch_target, bad);
            end
            if (bad)
            begin
                $display("test %0d failed", pend_id);
                fails = fails + 1;
            end
            else
            begin
                $display("test %0d ok", pend_id);
                passes = passes + 1;
            end
        end
    end

endmodule

// ==== ex_operands_if.sv ====
`timescale 1ns/100ps

// Resolved operands on their way into the ALU
interface ex_operands_if;

    logic valid;
    exec_pkg::op_e op;
    exec_pkg::xword_t a;
    exec_pkg::xword_t b;
    exec_pkg::xword_t imm;
    exec_pkg::xword_t pc;
    exec_pkg::regno_t rd;

    modport bypass (
        output valid,
        output op,
        output a,
        output b,
        output imm,
        output pc,
        output rd
    );

    modport alu (
        input valid,
        input op,
        input a,
        input b,
        input imm,
        input pc,
        input rd
    );

endinterface

// ==== ex_result_if.sv ====
`timescale 1ns/100ps

// Unregistered ALU and branch results
interface ex_result_if;

    logic valid;
    exec_pkg::xword_t value;
    logic write_rd;
    exec_pkg::regno_t rd;
    logic taken;
    exec_pkg::xword_t target;

    modport alu (
        output valid,
        output value,
        output write_rd,
        output rd,
        output taken,
        output target
    );

    modport latch (
        input valid,
        input value,
        input write_rd,
        input rd,
        input taken,
        input target
    );

endinterface

// ==== ex_result_reg.sv ====
`timescale 1ns/100ps

module ex_result_reg (
    input  logic clk,
    input  logic reset,
    input  logic kill,
    ex_result_if.latch res,
    output logic result_valid,
    output logic write_rd,
    output logic branch_taken,
    output exec_pkg::xword_t result,
    output exec_pkg::xword_t branch_target,
    output exec_pkg::regno_t rd_regno_out
);

    logic capture;

    // Killed or idle slots become bubbles
    assign capture = res.valid && !kill;

    always_ff @(posedge clk)
    begin
        if (reset || !capture)
        begin
            result_valid <= 1'b0;
            write_rd <= 1'b0;
            branch_taken <= 1'b0;
        end
        else
        begin
            result_valid <= 1'b1;
            write_rd <= res.write_rd;
            branch_taken <= res.taken;
        end
    end

    always_ff @(posedge clk)
    begin
        if (capture)
        begin
            result <= res.value;
            branch_target <= res.target;
            rd_regno_out <= res.rd;
        end
    end

endmodule

// ==== exec_alu.sv ====
`timescale 1ns/100ps

module exec_alu (
    ex_operands_if.alu ops,
    ex_result_if.alu res
);

    logic signed [exec_pkg::XLEN-1:0] a_s;
    logic [exec_pkg::SHAMT_W-1:0] shamt_r;
    logic [exec_pkg::SHAMT_W-1:0] shamt_i;
    logic lt_rs;
    logic lt_ru;
    logic lt_is;
    logic eq;
    exec_pkg::xword_t link;

    assign a_s = ops.a;
    assign shamt_r = ops.b[exec_pkg::SHAMT_W-1:0];
    assign shamt_i = ops.imm[exec_pkg::SHAMT_W-1:0];

    // Comparisons shared by slt forms and branches
    assign lt_rs = $signed(ops.a) < $signed(ops.b);
    assign lt_ru = ops.a < ops.b;
    assign lt_is = $signed(ops.a) < $signed(ops.imm);
    assign eq = ops.a == ops.b;

    assign link = ops.pc + exec_pkg::xword_t'(exec_pkg::INSN_BYTES);

    always_comb
    begin
        res.value = '0;
        res.write_rd = 1'b1;
        case (ops.op)
            exec_pkg::OP_ADD:  res.value = ops.a + ops.b;
            exec_pkg::OP_SUB:  res.value = ops.a - ops.b;
            exec_pkg::OP_AND:  res.value = ops.a & ops.b;
            exec_pkg::OP_OR:   res.value = ops.a | ops.b;
            exec_pkg::OP_XOR:  res.value = ops.a ^ ops.b;
            exec_pkg::OP_SLT:  res.value = exec_pkg::xword_t'(lt_rs);
            exec_pkg::OP_SLTU: res.value = exec_pkg::xword_t'(lt_ru);
            exec_pkg::OP_SLL:  res.value = ops.a << shamt_r;
            exec_pkg::OP_SRL:  res.value = ops.a >> shamt_r;
            exec_pkg::OP_SRA:  res.value = a_s >>> shamt_r;
            exec_pkg::OP_ADDI: res.value = ops.a + ops.imm;
            exec_pkg::OP_ANDI: res.value = ops.a & ops.imm;
            exec_pkg::OP_ORI:  res.value = ops.a | ops.imm;
            exec_pkg::OP_XORI: res.value = ops.a ^ ops.imm;
            exec_pkg::OP_SLTI: res.value = exec_pkg::xword_t'(lt_is);
            exec_pkg::OP_SLLI: res.value = ops.a << shamt_i;
            exec_pkg::OP_SRLI: res.value = ops.a >> shamt_i;
            exec_pkg::OP_SRAI: res.value = a_s >>> shamt_i;
            exec_pkg::OP_LUI:  res.value = ops.imm;
            exec_pkg::OP_JAL:  res.value = link;
            // Conditional branches leave rd alone
            default:
            begin
                res.write_rd = 1'b0;
            end
        endcase
    end

    always_comb
    begin
        case (ops.op)
            exec_pkg::OP_BEQ:  res.taken = eq;
            exec_pkg::OP_BNE:  res.taken = !eq;
            exec_pkg::OP_BLT:  res.taken = lt_rs;
            exec_pkg::OP_BGE:  res.taken = !lt_rs;
            exec_pkg::OP_BLTU: res.taken = lt_ru;
            exec_pkg::OP_BGEU: res.taken = !lt_ru;
            exec_pkg::OP_JAL:  res.taken = 1'b1;
            default:           res.taken = 1'b0;
        endcase
    end

    // pc-relative target, meaningful only when taken
    assign res.target = ops.pc + ops.imm;
    assign res.valid = ops.valid;
    assign res.rd = ops.rd;

endmodule

// ==== exec_pkg.sv ====
package exec_pkg;

    localparam int XLEN = 64;
    localparam int REGNO_W = 5;
    localparam int SHAMT_W = 6;

    // Step from an instruction to the next one, used for the jal link value
    localparam int INSN_BYTES = 4;

    typedef logic [XLEN-1:0] xword_t;
    typedef logic [REGNO_W-1:0] regno_t;

    typedef enum logic [4:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_SLTU,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_ADDI,
        OP_ANDI,
        OP_ORI,
        OP_XORI,
        OP_SLTI,
        OP_SLLI,
        OP_SRLI,
        OP_SRAI,
        OP_LUI,
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_BLTU,
        OP_BGEU,
        OP_JAL
    } op_e;

endpackage

// ==== execute_stage.f ====
exec_pkg.sv
ex_operands_if.sv
ex_result_if.sv
operand_bypass.sv
exec_alu.sv
ex_result_reg.sv
execute_stage.sv
ex_checker.sv
execute_stage_assertions.sv
tb_execute_stage.sv

// ==== execute_stage.sv ====
`timescale 1ns/100ps

module execute_stage (
    input  logic clk,
    input  logic reset,
    input  logic issue_valid,
    input  exec_pkg::op_e op,
    input  exec_pkg::regno_t rs1_regno,
    input  exec_pkg::regno_t rs2_regno,
    input  exec_pkg::regno_t rd_regno,
    input  exec_pkg::xword_t rs1_value,
    input  exec_pkg::xword_t rs2_value,
    input  exec_pkg::xword_t imm,
    input  exec_pkg::xword_t pc,
    input  logic kill,
    input  exec_pkg::regno_t mm_rd_regno,
    input  logic mm_write,
    input  exec_pkg::xword_t mm_data,
    input  exec_pkg::regno_t wb_rd_regno,
    input  logic wb_write,
    input  exec_pkg::xword_t wb_data,
    output logic result_valid,
    output exec_pkg::xword_t result,
    output exec_pkg::regno_t rd_regno_out,
    output logic write_rd,
    output logic branch_taken,
    output exec_pkg::xword_t branch_target
);

    ex_operands_if ops_bus ();
    ex_result_if res_bus ();

    // Own registered result is the youngest forwarding source.
    // write_rd is already cleared whenever result_valid is low.
    operand_bypass u_bypass (
        .issue_valid (issue_valid),
        .op          (op),
        .rs1_regno   (rs1_regno),
        .rs2_regno   (rs2_regno),
        .rd_regno    (rd_regno),
        .rs1_value   (rs1_value),
        .rs2_value   (rs2_value),
        .imm         (imm),
        .pc          (pc),
        .ex_rd       (rd_regno_out),
        .ex_write    (write_rd),
        .ex_value    (result),
        .mm_rd_regno (mm_rd_regno),
        .mm_write    (mm_write),
        .mm_data     (mm_data),
        .wb_rd_regno (wb_rd_regno),
        .wb_write    (wb_write),
        .wb_data     (wb_data),
        .ops         (ops_bus.bypass)
    );

    exec_alu u_alu (
        .ops (ops_bus.alu),
        .res (res_bus.alu)
    );

    ex_result_reg u_result (
        .clk           (clk),
        .reset         (reset),
        .kill          (kill),
        .res           (res_bus.latch),
        .result_valid  (result_valid),
        .write_rd      (write_rd),
        .branch_taken  (branch_taken),
        .result        (result),
        .branch_target (branch_target),
        .rd_regno_out  (rd_regno_out)
    );

endmodule

// ==== execute_stage_assertions.sv ====
`timescale 1ns/100ps

module execute_stage_assertions (
    input logic clk,
    input logic reset,
    input logic issue_valid,
    input logic kill,
    input logic result_valid,
    input logic write_rd,
    input logic branch_taken
);

    logic accepted;

    assign accepted = issue_valid && !kill;

    a_reset_clears: assert property (@(posedge clk) reset |=> !result_valid)
        else $error("result_valid high after reset");

    a_valid_follows: assert property (@(posedge clk) disable iff (reset)
        accepted |=> result_valid)
        else $error("accepted instruction gave no result_valid");

    a_no_extra_valid: assert property (@(posedge clk) disable iff (reset)
        !accepted |=> !result_valid)
        else $error("result_valid without an accepted instruction");

    a_taken_valid: assert property (@(posedge clk) disable iff (reset)
        branch_taken |-> result_valid)
        else $error("branch_taken without result_valid");

    a_write_valid: assert property (@(posedge clk) disable iff (reset)
        write_rd |-> result_valid)
        else $error("write_rd without result_valid");

endmodule

bind execute_stage execute_stage_assertions u_assertions (
    .clk          (clk),
    .reset        (reset),
    .issue_valid  (issue_valid),
    .kill         (kill),
    .result_valid (result_valid),
    .write_rd     (write_rd),
    .branch_taken (branch_taken)
);

// ==== operand_bypass.sv ====
`timescale 1ns/100ps

module operand_bypass (
    input  logic issue_valid,
    input  exec_pkg::op_e op,
    input  exec_pkg::regno_t rs1_regno,
    input  exec_pkg::regno_t rs2_regno,
    input  exec_pkg::regno_t rd_regno,
    input  exec_pkg::xword_t rs1_value,
    input  exec_pkg::xword_t rs2_value,
    input  exec_pkg::xword_t imm,
    input  exec_pkg::xword_t pc,
    input  exec_pkg::regno_t ex_rd,
    input  logic ex_write,
    input  exec_pkg::xword_t ex_value,
    input  exec_pkg::regno_t mm_rd_regno,
    input  logic mm_write,
    input  exec_pkg::xword_t mm_data,
    input  exec_pkg::regno_t wb_rd_regno,
    input  logic wb_write,
    input  exec_pkg::xword_t wb_data,
    ex_operands_if.bypass ops
);

    // Youngest producer wins; x0 is hardwired to zero
    function automatic exec_pkg::xword_t pick(
        input exec_pkg::regno_t regno,
        input exec_pkg::xword_t rf_value
    );
        exec_pkg::xword_t sel;
        if (regno == '0)
        begin
            sel = '0;
        end
        else if (ex_write && (ex_rd == regno))
        begin
            sel = ex_value;
        end
        else if (mm_write && (mm_rd_regno == regno))
        begin
            sel = mm_data;
        end
        else if (wb_write && (wb_rd_regno == regno))
        begin
            sel = wb_data;
        end
        else
        begin
            sel = rf_value;
        end
        return sel;
    endfunction

    always_comb
    begin
        ops.a = pick(rs1_regno, rs1_value);
        ops.b = pick(rs2_regno, rs2_value);
    end

    assign ops.valid = issue_valid;
    assign ops.op = op;
    assign ops.imm = imm;
    assign ops.pc = pc;
    assign ops.rd = rd_regno;

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_execute_stage \
    -f execute_stage.f -o sim_execute_stage || exit 1

out=$(./obj_dir/sim_execute_stage)
echo "$out"
echo "$out" | grep -qx "sim passed" && exit 0 || exit 1

// ==== tb_execute_stage.sv ====
`timescale 1ns/100ps

module tb_execute_stage;

    localparam int RAND_TESTS = 60;

    typedef struct {
        logic iv;
        exec_pkg::op_e op;
        exec_pkg::regno_t rs1;
        exec_pkg::regno_t rs2;
        exec_pkg::regno_t rd;
        exec_pkg::xword_t v1;
        exec_pkg::xword_t v2;
        exec_pkg::xword_t imm;
        exec_pkg::xword_t pc;
        logic kill;
        exec_pkg::regno_t mrd;
        exec_pkg::regno_t wrd;
        logic mw;
        logic ww;
        exec_pkg::xword_t md;
        exec_pkg::xword_t wd;
        logic ev;
        logic ew;
        logic et;
        exec_pkg::xword_t er;
    } entry_t;

    logic clk = 1'b0;
    logic reset = 1'b1;
    logic issue_valid = 1'b0;
    exec_pkg::op_e op = exec_pkg::OP_ADD;
    exec_pkg::regno_t rs1_regno = '0;
    exec_pkg::regno_t rs2_regno = '0;
    exec_pkg::regno_t rd_regno = '0;
    exec_pkg::xword_t rs1_value = '0;
    exec_pkg::xword_t rs2_value = '0;
    exec_pkg::xword_t imm = '0;
    exec_pkg::xword_t pc = '0;
    logic kill = 1'b0;
    exec_pkg::regno_t mm_rd_regno = '0;
    exec_pkg::regno_t wb_rd_regno = '0;
    logic mm_write = 1'b0;
    logic wb_write = 1'b0;
    exec_pkg::xword_t mm_data = '0;
    exec_pkg::xword_t wb_data = '0;
    logic result_valid;
    logic write_rd;
    logic branch_taken;
    exec_pkg::xword_t result;
    exec_pkg::xword_t branch_target;
    exec_pkg::regno_t rd_regno_out;

    logic check_en = 1'b0;
    int test_id = 0;
    logic exp_valid = 1'b0;
    logic exp_write = 1'b0;
    logic exp_taken = 1'b0;
    exec_pkg::xword_t exp_result = '0;
    exec_pkg::xword_t exp_target = '0;
    exec_pkg::regno_t exp_rd = '0;
    int pass_count;
    int fail_count;
    int done_count;
    entry_t table_q[$];
    logic [31:0] lfsr_state = 32'd67779;

    execute_stage dut0 (.*);

    ex_checker u_checker (.*);

    initial
    begin
        forever #2 clk = ~clk;
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic exec_pkg::xword_t rand_bits(input int n);
        exec_pkg::xword_t v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[62:0], lfsr_bit()};
        return v;
    endfunction

    // Reference behavior of the ALU and branch unit
    task automatic predict(input exec_pkg::op_e o, input exec_pkg::xword_t a,
                           input exec_pkg::xword_t b, input exec_pkg::xword_t im,
                           input exec_pkg::xword_t p, output exec_pkg::xword_t val,
                           output logic wr, output logic tk);
        logic [5:0] sb;
        logic [5:0] si;
        sb = b[5:0];
        si = im[5:0];
        val = '0;
        wr = 1'b1;
        tk = 1'b0;
        case (o)
            exec_pkg::OP_ADD:  val = a + b;
            exec_pkg::OP_SUB:  val = a - b;
            exec_pkg::OP_AND:  val = a & b;
            exec_pkg::OP_OR:   val = a | b;
            exec_pkg::OP_XOR:  val = a ^ b;
            exec_pkg::OP_SLT:  val = 64'($signed(a) < $signed(b));
            exec_pkg::OP_SLTU: val = 64'(a < b);
            exec_pkg::OP_SLL:  val = a << sb;
            exec_pkg::OP_SRL:  val = a >> sb;
            exec_pkg::OP_SRA:  val = $signed(a) >>> sb;
            exec_pkg::OP_ADDI: val = a + im;
            exec_pkg::OP_ANDI: val = a & im;
            exec_pkg::OP_ORI:  val = a | im;
            exec_pkg::OP_XORI: val = a ^ im;
            exec_pkg::OP_SLTI: val = 64'($signed(a) < $signed(im));
            exec_pkg::OP_SLLI: val = a << si;
            exec_pkg::OP_SRLI: val = a >> si;
            exec_pkg::OP_SRAI: val = $signed(a) >>> si;
            exec_pkg::OP_LUI:  val = im;
            exec_pkg::OP_JAL:
            begin
                val = p + 64'd4;
                tk = 1'b1;
            end
            default:
            begin
                wr = 1'b0;
                case (o)
                    exec_pkg::OP_BEQ:  tk = a == b;
                    exec_pkg::OP_BNE:  tk = a != b;
                    exec_pkg::OP_BLT:  tk = $signed(a) < $signed(b);
                    exec_pkg::OP_BGE:  tk = $signed(a) >= $signed(b);
                    exec_pkg::OP_BLTU: tk = a < b;
                    default:           tk = a >= b;
                endcase
            end
        endcase
    endtask

    task automatic add(input logic iv, input exec_pkg::op_e o, input exec_pkg::regno_t r1,
                       input exec_pkg::regno_t r2, input exec_pkg::regno_t rd,
                       input exec_pkg::xword_t v1, input exec_pkg::xword_t v2,
                       input exec_pkg::xword_t im, input exec_pkg::xword_t p, input logic k,
                       input exec_pkg::regno_t mrd, input logic mw, input exec_pkg::xword_t md,
                       input exec_pkg::regno_t wrd, input logic ww, input exec_pkg::xword_t wd,
                       input logic ev, input exec_pkg::xword_t er, input logic ew,
                       input logic et);
        entry_t e;
        e = '{iv, o, r1, r2, rd, v1, v2, im, p, k, mrd, wrd, mw, ww, md, wd, ev, ew, et, er};
        table_q.push_back(e);
    endtask

    task automatic apply(input entry_t e, input int id);
        issue_valid = e.iv;
        op = e.op;
        rs1_regno = e.rs1;
        rs2_regno = e.rs2;
        rd_regno = e.rd;
        rs1_value = e.v1;
        rs2_value = e.v2;
        imm = e.imm;
        pc = e.pc;
        kill = e.kill;
        mm_rd_regno = e.mrd;
        mm_write = e.mw;
        mm_data = e.md;
        wb_rd_regno = e.wrd;
        wb_write = e.ww;
        wb_data = e.wd;
        check_en = 1'b1;
        test_id = id;
        exp_valid = e.ev;
        exp_result = e.er;
        exp_write = e.ew;
        exp_taken = e.et;
        exp_target = e.pc + e.imm;
        exp_rd = e.rd;
    endtask

    initial
    begin
        entry_t e;
        int waited;
        int total;
        // Idle slot right after reset, then hazard free ALU ops
        add(0, exec_pkg::OP_ADD, 0, 0, 0, 0, 0, 0, 'h100, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        add(1, exec_pkg::OP_ADD, 1, 2, 3, 5, 7, 0, 'h100, 0, 0, 0, 0, 0, 0, 0, 1, 12, 1, 0);
        // Back to back use of x3
        add(1, exec_pkg::OP_SUB, 3, 2, 4, 99, 2, 0, 'h100, 0, 0, 0, 0, 0, 0, 0, 1, 10, 1, 0);
        add(1, exec_pkg::OP_AND, 1, 2, 6, 'hf0, 'h3c, 0, 'h100, 0,
            0, 0, 0, 0, 0, 0, 1, 'h30, 1, 0);
        add(1, exec_pkg::OP_OR, 1, 2, 7, 'hf0, 'h0f, 0, 'h100, 0,
            0, 0, 0, 0, 0, 0, 1, 'hff, 1, 0);
        add(1, exec_pkg::OP_XOR, 1, 2, 8, 'hff, 'h0f, 0, 'h100, 0,
            0, 0, 0, 0, 0, 0, 1, 'hf0, 1, 0);
        add(1, exec_pkg::OP_SLT, 1, 2, 9, '1, 1, 0, 'h100, 0, 0, 0, 0, 0, 0, 0, 1, 1, 1, 0);
        add(1, exec_pkg::OP_SLTU, 1, 2, 10, '1, 1, 0, 'h100, 0, 0, 0, 0, 0, 0, 0, 1, 0, 1, 0);
        add(1, exec_pkg::OP_SRA, 1, 2, 11, 64'h8000_0000_0000_0000, 4, 0, 'h100, 0,
            0, 0, 0, 0, 0, 0, 1, 64'hf800_0000_0000_0000, 1, 0);
        add(1, exec_pkg::OP_ADDI, 1, 0, 12, 10, 0, -64'sd3, 'h100, 0,
            0, 0, 0, 0, 0, 0, 1, 7, 1, 0);
        add(1, exec_pkg::OP_LUI, 0, 0, 13, 0, 0, 'h12345000, 'h100, 0,
            0, 0, 0, 0, 0, 0, 1, 'h12345000, 1, 0);
        // Memory stage beats writeback
        add(1, exec_pkg::OP_ADD, 14, 15, 16, 1, 2, 0, 'h100, 0,
            14, 1, 100, 14, 1, 200, 1, 102, 1, 0);
        // Sources without a write flag are ignored
        add(1, exec_pkg::OP_ADD, 17, 18, 19, 5, 6, 0, 'h100, 0,
            17, 0, 1000, 18, 0, 2000, 1, 11, 1, 0);
        // x0 stays zero even when named by a forwarding source
        add(1, exec_pkg::OP_ADD, 0, 20, 21, 55, 3, 0, 'h100, 0,
            0, 1, 77, 0, 1, 88, 1, 3, 1, 0);
        add(1, exec_pkg::OP_BEQ, 1, 2, 0, 4, 4, 'h20, 'h100, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 1);
        add(1, exec_pkg::OP_BEQ, 1, 2, 0, 4, 5, 'h20, 'h100, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0);
        add(1, exec_pkg::OP_BNE, 1, 2, 0, 4, 4, 'h20, 'h100, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0);
        add(1, exec_pkg::OP_BNE, 1, 2, 0, 4, 5, 'h20, 'h100, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 1);
        add(1, exec_pkg::OP_BLT, 1, 2, 0, '1, 1, 'h10, 'h200, 0,
            0, 0, 0, 0, 0, 0, 1, 0, 0, 1);
        add(1, exec_pkg::OP_BLT, 1, 2, 0, 1, '1, 'h10, 'h200, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0);
        add(1, exec_pkg::OP_BGE, 1, 2, 0, 1, '1, 'h18, 'h200, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 1);
        add(1, exec_pkg::OP_BGE, 1, 2, 0, '1, 1, 'h18, 'h200, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0);
        add(1, exec_pkg::OP_BLTU, 1, 2, 0, 1, '1, 'h8, 'h300, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 1);
        add(1, exec_pkg::OP_BLTU, 1, 2, 0, '1, 1, 'h8, 'h300, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0);
        add(1, exec_pkg::OP_BGEU, 1, 2, 0, '1, 1, -64'sd8, 'h300, 0,
            0, 0, 0, 0, 0, 0, 1, 0, 0, 1);
        add(1, exec_pkg::OP_BGEU, 1, 2, 0, 1, '1, 'h8, 'h300, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0);
        add(1, exec_pkg::OP_JAL, 0, 0, 1, 0, 0, 'h40, 'h400, 0,
            0, 0, 0, 0, 0, 0, 1, 'h404, 1, 1);
        add(1, exec_pkg::OP_ADD, 1, 2, 22, 1, 2, 0, 'h100, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        // Killed x22 must not reach its successor
        add(1, exec_pkg::OP_ADD, 22, 2, 23, 50, 2, 0, 'h100, 0,
            0, 0, 0, 0, 0, 0, 1, 52, 1, 0);

        // Random opcodes, no hazards since rd never names x1 or x2
        for (int i = 0; i < RAND_TESTS; i++)
        begin
            e = '{1'b1, exec_pkg::op_e'(rand_bits(5) % 26), 1, 2,
                  exec_pkg::regno_t'(3 + (i % 29)),
                  rand_bits(64), rand_bits(64), rand_bits(64), rand_bits(64), 1'b0,
                  0, 0, 1'b0, 1'b0, '0, '0, 1'b1, 1'b0, 1'b0, '0};
            predict(e.op, e.v1, e.v2, e.imm, e.pc, e.er, e.ew, e.et);
            table_q.push_back(e);
        end
        total = table_q.size();

        repeat (10) @(posedge clk);
        #0.5;
        reset = 1'b0;
        foreach (table_q[i])
        begin
            apply(table_q[i], i);
            @(posedge clk);
            #0.5;
        end
        issue_valid = 1'b0;
        kill = 1'b0;
        check_en = 1'b0;

        waited = 0;
        while (done_count < total && waited < 20)
        begin
            @(posedge clk);
            waited++;
        end
        if (done_count < total)
            $display("timeout: only %0d of %0d tests were checked", done_count, total);
        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0 && done_count == total)
        begin
            $display("sim passed");
        end
        else
        begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
